/* hdl/fe_cfg_pkg.sv */
package fe_cfg_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // RF channels on the board
  localparam int NUM_CHANNELS = 2;

  // Channel code in the upper address bits
  // Codes 2 and 3 decode to nothing
  localparam int CH_SEL_W = 2;

  // ATR state in the lower address bits
  localparam int ATR_SEL_W = 2;
  localparam int NUM_ATR_STATES = 2 ** ATR_SEL_W;

  localparam int CFG_ADDR_W = CH_SEL_W + ATR_SEL_W;
  localparam int CFG_DATA_W = 32;

  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;
  typedef logic [CH_SEL_W-1:0]   ch_sel_t;

  //////////////////////////////
  // State encodings
  //////////////////////////////

  // TX activity bit over RX activity bit
  typedef enum logic [ATR_SEL_W-1:0] {
    ATR_IDLE        = 2'b00,
    ATR_RX_ONLY     = 2'b01,
    ATR_TX_ONLY     = 2'b10,
    ATR_FULL_DUPLEX = 2'b11
  } atr_state_t;

  // Register port FSM, one hold cycle per write
  typedef enum logic {DEC_IDLE, DEC_HOLD} dec_state_t;

endpackage

/* hdl/fe_pins_pkg.sv */
package fe_pins_pkg;

  //////////////////////////////
  // Channel pin word
  //////////////////////////////

  localparam int GPIO_W = 16;

  // Band select fields
  localparam int TX_BS_LSB  = 0;
  localparam int RX_BS_LSB  = 3;
  localparam int RXB_BS_LSB = 6;
  localparam int RXC_BS_LSB = 8;

  // Single bit controls
  localparam int TX_EN_A_BIT = 10;
  localparam int TX_EN_B_BIT = 11;
  localparam int TXRX_V2_BIT = 12;
  localparam int TXRX_V1_BIT = 13;
  localparam int RX_V2_BIT   = 14;
  localparam int RX_V1_BIT   = 15;

  //////////////////////////////
  // LED field
  //////////////////////////////

  // Sits above the pin word in a data word
  localparam int LED_LSB = 16;
  localparam int LED_W   = 3;

  localparam int LED_TXRX_RX_BIT = 0;
  localparam int LED_TXRX_TX_BIT = 1;
  localparam int LED_RX_RX_BIT   = 2;

  typedef logic [GPIO_W-1:0] gpio_word_t;
  typedef logic [LED_W-1:0]  led_t;
  typedef logic [2:0]        bandsel3_t;
  typedef logic [1:0]        bandsel2_t;

endpackage

/* hdl/fe_chan_if.sv */
interface fe_chan_if
  import fe_cfg_pkg::*;
  import fe_pins_pkg::*;
();

  // Write strobe from the register port, one cycle wide
  logic       wr_en;
  // Which of the four ATR words to load
  atr_state_t reg_sel;
  // Pin word in the low half, LED field above it
  cfg_data_t  wr_data;

  // Selected word, registered in the channel
  gpio_word_t pins;
  led_t       leds;

  modport decode (output wr_en, reg_sel, wr_data);

  modport chan (
    input  wr_en, reg_sel, wr_data,
    output pins, leds
  );

  modport map (input pins, leds);

endinterface

/* hdl/fe_reg_decode.sv */
module fe_reg_decode
  import fe_cfg_pkg::*;
(
  input  logic      bus_clk,
  input  logic      bus_rst,
  input  logic      i_cfg_valid,
  output logic      o_cfg_ready,
  input  cfg_addr_t i_cfg_addr,
  input  cfg_data_t i_cfg_data,
  fe_chan_if.decode chan_o [NUM_CHANNELS]
);

  dec_state_t state;
  cfg_addr_t  hold_addr;
  cfg_data_t  hold_data;
  ch_sel_t    hold_ch;
  logic       cfg_take;

  // Ready drops for the hold cycle only
  assign o_cfg_ready = (state == DEC_IDLE);
  assign cfg_take    = i_cfg_valid && o_cfg_ready;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state <= DEC_IDLE;
    end else begin
      case (state)
        DEC_IDLE: if (cfg_take) state <= DEC_HOLD;
        DEC_HOLD: state <= DEC_IDLE;
        default:  state <= DEC_IDLE;
      endcase
    end
  end

  // Holding register for the accepted write
  always_ff @(posedge bus_clk) begin
    if (cfg_take) begin
      hold_addr <= i_cfg_addr;
      hold_data <= i_cfg_data;
    end
  end

  assign hold_ch = hold_addr[CFG_ADDR_W-1 -: CH_SEL_W];

  // Strobe only the addressed channel
  // Unused channel codes match no slot and the write is dropped
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_route
    assign chan_o[c].wr_en   = (state == DEC_HOLD) && (hold_ch == ch_sel_t'(c));
    assign chan_o[c].reg_sel = atr_state_t'(hold_addr[ATR_SEL_W-1:0]);
    assign chan_o[c].wr_data = hold_data;
  end

endmodule

/* hdl/fe_atr_chan.sv */
module fe_atr_chan
  import fe_cfg_pkg::*;
  import fe_pins_pkg::*;
(
  input logic     bus_clk,
  input logic     bus_rst,
  input logic     i_rx_atr,
  input logic     i_tx_atr,
  fe_chan_if.chan chan
);

  //////////////////////////////
  // ATR word storage
  //////////////////////////////

  // One pin word and one LED field per ATR state
  gpio_word_t word_mem [NUM_ATR_STATES];
  led_t       led_mem  [NUM_ATR_STATES];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int s = 0; s < NUM_ATR_STATES; s++) begin
        word_mem[s] <= '0;
        led_mem[s]  <= '0;
      end
    end else if (chan.wr_en) begin
      // Low half to the pins, LED bits from above
      word_mem[chan.reg_sel] <= chan.wr_data[GPIO_W-1:0];
      led_mem[chan.reg_sel]  <= chan.wr_data[LED_LSB +: LED_W];
    end
  end

  //////////////////////////////
  // ATR selection
  //////////////////////////////

  atr_state_t atr_state;

  // TX over RX, same order as the enum
  assign atr_state = atr_state_t'({i_tx_atr, i_rx_atr});

  // Word for the current activity, one edge late
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      chan.pins <= '0;
      chan.leds <= '0;
    end else begin
      chan.pins <= word_mem[atr_state];
      chan.leds <= led_mem[atr_state];
    end
  end

endmodule

/* hdl/fe_pin_map.sv */
module fe_pin_map
  import fe_cfg_pkg::*;
  import fe_pins_pkg::*;
(
  input  logic      bus_clk,
  input  logic      bus_rst,
  fe_chan_if.map    ch [NUM_CHANNELS],
  // Shared by both banks
  output bandsel3_t o_tx_bandsel,
  // Bank 1
  output bandsel3_t o_rx1_bandsel,
  output bandsel2_t o_rx1b_bandsel,
  output bandsel2_t o_rx1c_bandsel,
  output logic      o_tx_enable1a,
  output logic      o_tx_enable1b,
  output logic      o_vctxrx1_v1,
  output logic      o_vctxrx1_v2,
  output logic      o_vcrx1_v1,
  output logic      o_vcrx1_v2,
  output logic      o_led_txrx1_tx,
  output logic      o_led_txrx1_rx,
  output logic      o_led_rx1_rx,
  // Bank 2
  output bandsel3_t o_rx2_bandsel,
  output bandsel2_t o_rx2b_bandsel,
  output bandsel2_t o_rx2c_bandsel,
  output logic      o_tx_enable2a,
  output logic      o_tx_enable2b,
  output logic      o_vctxrx2_v1,
  output logic      o_vctxrx2_v2,
  output logic      o_vcrx2_v1,
  output logic      o_vcrx2_v2,
  output logic      o_led_txrx2_tx,
  output logic      o_led_txrx2_rx,
  output logic      o_led_rx2_rx
);

  // Board wiring, banks swapped against channel numbers
  localparam int BANK1_CH = 1;
  localparam int BANK2_CH = 0;

  localparam int BS3_W = $bits(bandsel3_t);
  localparam int BS2_W = $bits(bandsel2_t);

  //////////////////////////////
  // Output registers
  //////////////////////////////

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_reg
    gpio_word_t pins_q;
    led_t       leds_q;

    always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
        pins_q <= '0;
        leds_q <= '0;
      end else begin
        pins_q <= ch[c].pins;
        leds_q <= ch[c].leds;
      end
    end
  end

  // One TX filter bank for both channels
  // Either channel may set it
  bandsel3_t tx_bs_q;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      tx_bs_q <= '0;
    end else begin
      tx_bs_q <= ch[BANK1_CH].pins[TX_BS_LSB +: BS3_W] |
                 ch[BANK2_CH].pins[TX_BS_LSB +: BS3_W];
    end
  end

  assign o_tx_bandsel = tx_bs_q;

  //////////////////////////////
  // Bank 1 from channel 1
  //////////////////////////////

  assign o_rx1_bandsel  = g_reg[BANK1_CH].pins_q[RX_BS_LSB +: BS3_W];
  assign o_rx1b_bandsel = g_reg[BANK1_CH].pins_q[RXB_BS_LSB +: BS2_W];
  assign o_rx1c_bandsel = g_reg[BANK1_CH].pins_q[RXC_BS_LSB +: BS2_W];
  assign o_tx_enable1a  = g_reg[BANK1_CH].pins_q[TX_EN_A_BIT];
  assign o_tx_enable1b  = g_reg[BANK1_CH].pins_q[TX_EN_B_BIT];
  // Antenna switches
  assign o_vctxrx1_v2   = g_reg[BANK1_CH].pins_q[TXRX_V2_BIT];
  assign o_vctxrx1_v1   = g_reg[BANK1_CH].pins_q[TXRX_V1_BIT];
  assign o_vcrx1_v2     = g_reg[BANK1_CH].pins_q[RX_V2_BIT];
  assign o_vcrx1_v1     = g_reg[BANK1_CH].pins_q[RX_V1_BIT];
  assign o_led_txrx1_rx = g_reg[BANK1_CH].leds_q[LED_TXRX_RX_BIT];
  assign o_led_txrx1_tx = g_reg[BANK1_CH].leds_q[LED_TXRX_TX_BIT];
  assign o_led_rx1_rx   = g_reg[BANK1_CH].leds_q[LED_RX_RX_BIT];

  //////////////////////////////
  // Bank 2 from channel 0
  //////////////////////////////

  assign o_rx2_bandsel  = g_reg[BANK2_CH].pins_q[RX_BS_LSB +: BS3_W];
  assign o_rx2b_bandsel = g_reg[BANK2_CH].pins_q[RXB_BS_LSB +: BS2_W];
  assign o_rx2c_bandsel = g_reg[BANK2_CH].pins_q[RXC_BS_LSB +: BS2_W];
  assign o_tx_enable2a  = g_reg[BANK2_CH].pins_q[TX_EN_A_BIT];
  assign o_tx_enable2b  = g_reg[BANK2_CH].pins_q[TX_EN_B_BIT];
  // Antenna switches
  assign o_vctxrx2_v2   = g_reg[BANK2_CH].pins_q[TXRX_V2_BIT];
  assign o_vctxrx2_v1   = g_reg[BANK2_CH].pins_q[TXRX_V1_BIT];
  assign o_vcrx2_v2     = g_reg[BANK2_CH].pins_q[RX_V2_BIT];
  assign o_vcrx2_v1     = g_reg[BANK2_CH].pins_q[RX_V1_BIT];
  assign o_led_txrx2_rx = g_reg[BANK2_CH].leds_q[LED_TXRX_RX_BIT];
  assign o_led_txrx2_tx = g_reg[BANK2_CH].leds_q[LED_TXRX_TX_BIT];
  assign o_led_rx2_rx   = g_reg[BANK2_CH].leds_q[LED_RX_RX_BIT];

endmodule

/* hdl/pwr_button_irq.sv */
module pwr_button_irq #(
  // Pulse length in bus_clk cycles, two or more
  parameter int STRETCH_CYCLES = 8
) (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic i_onswitch_n,
  output logic o_press_irq,
  output logic o_release_irq
);

  // Two earlier samples of the switch, already debounced
  logic [1:0] sw_hist;
  logic       press_det;
  logic       release_det;

  logic [STRETCH_CYCLES-1:0] press_sr;
  logic [STRETCH_CYCLES-1:0] release_sr;

  // Active low switch
  // Low now after two high samples
  assign press_det   = ~i_onswitch_n & sw_hist[0] & sw_hist[1];
  // High now after two low samples
  assign release_det = i_onswitch_n & ~sw_hist[0] & ~sw_hist[1];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      // Start from the released level
      sw_hist    <= 2'b11;
      press_sr   <= '0;
      release_sr <= '0;
    end else begin
      sw_hist    <= {sw_hist[0], i_onswitch_n};
      // Stretch each edge so the IRQ is not missed
      press_sr   <= {press_sr[STRETCH_CYCLES-2:0], press_det};
      release_sr <= {release_sr[STRETCH_CYCLES-2:0], release_det};
    end
  end

  assign o_press_irq   = |press_sr;
  assign o_release_irq = |release_sr;

endmodule

/* hdl/e31x_fe_ctrl.sv */
module e31x_fe_ctrl
  import fe_cfg_pkg::*;
  import fe_pins_pkg::*;
#(
  parameter int STRETCH_CYCLES = 8
) (
  input  logic                    bus_clk,
  input  logic                    bus_rst,
  // Register write port
  input  logic                    i_cfg_valid,
  output logic                    o_cfg_ready,
  input  cfg_addr_t               i_cfg_addr,
  input  cfg_data_t               i_cfg_data,
  // Radio activity, one bit per channel
  input  logic [NUM_CHANNELS-1:0] i_rx_atr,
  input  logic [NUM_CHANNELS-1:0] i_tx_atr,
  // Power switch, active low
  input  logic                    i_onswitch_n,
  // Front-end pins
  output bandsel3_t               o_tx_bandsel,
  output bandsel3_t               o_rx1_bandsel,
  output bandsel2_t               o_rx1b_bandsel,
  output bandsel2_t               o_rx1c_bandsel,
  output logic                    o_tx_enable1a,
  output logic                    o_tx_enable1b,
  output logic                    o_vctxrx1_v1,
  output logic                    o_vctxrx1_v2,
  output logic                    o_vcrx1_v1,
  output logic                    o_vcrx1_v2,
  output logic                    o_led_txrx1_tx,
  output logic                    o_led_txrx1_rx,
  output logic                    o_led_rx1_rx,
  output bandsel3_t               o_rx2_bandsel,
  output bandsel2_t               o_rx2b_bandsel,
  output bandsel2_t               o_rx2c_bandsel,
  output logic                    o_tx_enable2a,
  output logic                    o_tx_enable2b,
  output logic                    o_vctxrx2_v1,
  output logic                    o_vctxrx2_v2,
  output logic                    o_vcrx2_v1,
  output logic                    o_vcrx2_v2,
  output logic                    o_led_txrx2_tx,
  output logic                    o_led_txrx2_rx,
  output logic                    o_led_rx2_rx,
  // Interrupts
  output logic                    o_press_irq,
  output logic                    o_release_irq
);

  //////////////////////////////
  // Radio front-end control
  //////////////////////////////

  // One link per channel
  fe_chan_if chan_if [NUM_CHANNELS] ();

  fe_reg_decode decode_i (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .i_cfg_valid (i_cfg_valid),
    .o_cfg_ready (o_cfg_ready),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_data  (i_cfg_data),
    .chan_o      (chan_if)
  );

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    fe_atr_chan chan_i (
      .bus_clk  (bus_clk),
      .bus_rst  (bus_rst),
      .i_rx_atr (i_rx_atr[c]),
      .i_tx_atr (i_tx_atr[c]),
      .chan     (chan_if[c])
    );
  end

  fe_pin_map map_i (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .ch             (chan_if),
    .o_tx_bandsel   (o_tx_bandsel),
    .o_rx1_bandsel  (o_rx1_bandsel),
    .o_rx1b_bandsel (o_rx1b_bandsel),
    .o_rx1c_bandsel (o_rx1c_bandsel),
    .o_tx_enable1a  (o_tx_enable1a),
    .o_tx_enable1b  (o_tx_enable1b),
    .o_vctxrx1_v1   (o_vctxrx1_v1),
    .o_vctxrx1_v2   (o_vctxrx1_v2),
    .o_vcrx1_v1     (o_vcrx1_v1),
    .o_vcrx1_v2     (o_vcrx1_v2),
    .o_led_txrx1_tx (o_led_txrx1_tx),
    .o_led_txrx1_rx (o_led_txrx1_rx),
    .o_led_rx1_rx   (o_led_rx1_rx),
    .o_rx2_bandsel  (o_rx2_bandsel),
    .o_rx2b_bandsel (o_rx2b_bandsel),
    .o_rx2c_bandsel (o_rx2c_bandsel),
    .o_tx_enable2a  (o_tx_enable2a),
    .o_tx_enable2b  (o_tx_enable2b),
    .o_vctxrx2_v1   (o_vctxrx2_v1),
    .o_vctxrx2_v2   (o_vctxrx2_v2),
    .o_vcrx2_v1     (o_vcrx2_v1),
    .o_vcrx2_v2     (o_vcrx2_v2),
    .o_led_txrx2_tx (o_led_txrx2_tx),
    .o_led_txrx2_rx (o_led_txrx2_rx),
    .o_led_rx2_rx   (o_led_rx2_rx)
  );

  //////////////////////////////
  // Power button
  //////////////////////////////

  pwr_button_irq #(
    .STRETCH_CYCLES (STRETCH_CYCLES)
  ) button_i (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_onswitch_n  (i_onswitch_n),
    .o_press_irq   (o_press_irq),
    .o_release_irq (o_release_irq)
  );

endmodule

/* verification/tb_e31x_fe_ctrl.sv */
module tb_e31x_fe_ctrl
  import fe_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int STRETCH = 8;

  typedef enum {OP_WRITE, OP_ATR, OP_BTN} op_t;

  // One row of the stimulus table
  typedef struct {
    op_t         op;
    int          test_id;
    logic [3:0]  addr;
    logic [31:0] data;
    logic [1:0]  rx;
    logic [1:0]  tx;
    logic        level;
    int          wait_cyc;
  } entry_t;

  logic       bus_clk;
  logic       bus_rst;
  logic       i_cfg_valid;
  logic       o_cfg_ready;
  cfg_addr_t  i_cfg_addr;
  cfg_data_t  i_cfg_data;
  logic [1:0] i_rx_atr;
  logic [1:0] i_tx_atr;
  logic       i_onswitch_n;
  logic [2:0] o_tx_bandsel, o_rx1_bandsel, o_rx2_bandsel;
  logic [1:0] o_rx1b_bandsel, o_rx1c_bandsel, o_rx2b_bandsel, o_rx2c_bandsel;
  logic       o_tx_enable1a, o_tx_enable1b, o_vctxrx1_v1, o_vctxrx1_v2, o_vcrx1_v1, o_vcrx1_v2;
  logic       o_tx_enable2a, o_tx_enable2b, o_vctxrx2_v1, o_vctxrx2_v2, o_vcrx2_v1, o_vcrx2_v2;
  logic       o_led_txrx1_tx, o_led_txrx1_rx, o_led_rx1_rx;
  logic       o_led_txrx2_tx, o_led_txrx2_rx, o_led_rx2_rx;
  logic       o_press_irq, o_release_irq;

  // Bank outputs packed like {leds, pin word}, TX band select left out
  logic [18:0] bank1_pins;
  logic [18:0] bank2_pins;
  assign bank1_pins = {o_led_rx1_rx, o_led_txrx1_tx, o_led_txrx1_rx, o_vcrx1_v1, o_vcrx1_v2,
                       o_vctxrx1_v1, o_vctxrx1_v2, o_tx_enable1b, o_tx_enable1a,
                       o_rx1c_bandsel, o_rx1b_bandsel, o_rx1_bandsel, 3'b000};
  assign bank2_pins = {o_led_rx2_rx, o_led_txrx2_tx, o_led_txrx2_rx, o_vcrx2_v1, o_vcrx2_v2,
                       o_vctxrx2_v1, o_vctxrx2_v2, o_tx_enable2b, o_tx_enable2a,
                       o_rx2c_bandsel, o_rx2b_bandsel, o_rx2_bandsel, 3'b000};

  // Reference state
  logic [18:0] model [NUM_CHANNELS][4];
  logic [1:0]  btn_hist;
  int          press_cnt;
  int          release_cnt;
  int          press_hi;
  int          release_hi;
  int          errors;
  int          checks;
  int          base_err;
  int          limit;
  entry_t      table_q [$];
  string       test_names [5] = '{"reset state", "pins per channel and ATR state",
                                  "shared TX band select", "register port handshake",
                                  "power button interrupts"};

  e31x_fe_ctrl #(.STRETCH_CYCLES(STRETCH)) dut_i (.*);

  always #4 bus_clk = ~bus_clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  // Word picked by a channel's activity, TX bit over RX bit
  function automatic logic [18:0] sel_word(input int ch);
    return model[ch][{i_tx_atr[ch], i_rx_atr[ch]}];
  endfunction

  // One clock, button model follows the DUT sample by sample
  task automatic step();
    logic press_det;
    logic release_det;
    @(posedge bus_clk);
    press_det   = !i_onswitch_n && (btn_hist == 2'b11);
    release_det = i_onswitch_n && (btn_hist == 2'b00);
    btn_hist    = {btn_hist[0], i_onswitch_n};
    press_cnt   = press_det ? STRETCH : ((press_cnt > 0) ? press_cnt - 1 : 0);
    release_cnt = release_det ? STRETCH : ((release_cnt > 0) ? release_cnt - 1 : 0);
    #1;
    if (o_press_irq) press_hi++;
    if (o_release_irq) release_hi++;
    check_val("o_press_irq", 32'(o_press_irq), 32'(press_cnt > 0));
    check_val("o_release_irq", 32'(o_release_irq), 32'(release_cnt > 0));
  endtask

  task automatic check_outputs();
    logic [18:0] exp1;
    logic [18:0] exp2;
    // Channel 1 feeds bank 1, channel 0 feeds bank 2
    exp1 = sel_word(1);
    exp2 = sel_word(0);
    check_val("o_tx_bandsel", 32'(o_tx_bandsel), 32'(exp1[2:0] | exp2[2:0]));
    check_val("bank1 pins", 32'(bank1_pins), 32'({exp1[18:3], 3'b000}));
    check_val("bank2 pins", 32'(bank2_pins), 32'({exp2[18:3], 3'b000}));
  endtask

  // Keep valid high after the take when a chained write follows
  task automatic do_write(input logic [3:0] addr, input logic [31:0] data, input bit keep);
    int  hold;
    bit  chained;
    int  ch;
    hold        = 0;
    chained     = i_cfg_valid;
    ch          = int'(addr[3:2]);
    i_cfg_valid = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_data  = data;
    while (!o_cfg_ready) begin
      step();
      hold++;
    end
    if (chained) begin
      assert (hold == 1) else begin
        $display("ready came back after %0d cycles instead of one", hold);
        errors++;
      end
    end
    step();
    // Unused channel codes store nothing
    if (ch < NUM_CHANNELS) model[ch][addr[1:0]] = {data[18:16], data[15:0]};
    check_val("o_cfg_ready", 32'(o_cfg_ready), 32'd0);
    if (!keep) i_cfg_valid = 1'b0;
  endtask

  task automatic add_entry(input op_t op, input int id, input logic [3:0] addr,
                           input logic [1:0] rx, input logic [1:0] tx, input logic level,
                           input int n);
    entry_t e;
    e.op       = op;
    e.test_id  = id;
    e.addr     = addr;
    e.data     = $urandom;
    e.rx       = rx;
    e.tx       = tx;
    e.level    = level;
    e.wait_cyc = n;
    table_q.push_back(e);
  endtask

  task automatic report(input int id);
    $display("test %0d %s: %0d errors", id, test_names[id], errors - base_err);
    base_err = errors;
  endtask

  //////////////////////////////
  // Timeout
  //////////////////////////////

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge bus_clk);
    $display("timeout, run did not finish within %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    entry_t     e;
    int         cur_test;
    logic [1:0] st0;
    logic [1:0] st1;
    bus_clk      = 1'b0;
    bus_rst      = 1'b1;
    i_cfg_valid  = 1'b0;
    i_cfg_addr   = '0;
    i_cfg_data   = '0;
    i_rx_atr     = 2'b00;
    i_tx_atr     = 2'b00;
    i_onswitch_n = 1'b1;
    btn_hist     = 2'b11;
    press_cnt    = 0;
    release_cnt  = 0;
    press_hi     = 0;
    release_hi   = 0;
    errors       = 0;
    checks       = 0;
    base_err     = 0;
    foreach (model[c, s]) model[c][s] = '0;
    void'($urandom(32'hafd2_7084));

    // Every word of both channels, then each ATR state
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int s = 0; s < 4; s++) begin
        add_entry(OP_WRITE, 1, {2'(c), 2'(s)}, 2'b00, 2'b00, 1'b1, 3);
      end
    end
    for (int s = 0; s < 4; s++) begin
      // Channels on opposite states, so a bank swap shows
      st0 = 2'(s);
      st1 = 2'(3 - s);
      add_entry(OP_ATR, 1, 4'h0, {st1[0], st0[0]}, {st1[1], st0[1]}, 1'b1, 2);
    end
    // Mixed activity
    for (int i = 0; i < 6; i++) begin
      add_entry(OP_ATR, 2, 4'h0, 2'($urandom), 2'($urandom), 1'b1, 2);
    end
    // Ch0 full duplex, ch1 RX only, then a chained pair and two unused codes
    add_entry(OP_ATR, 3, 4'h0, 2'b11, 2'b01, 1'b1, 2);
    add_entry(OP_WRITE, 3, 4'b0011, 2'b00, 2'b00, 1'b1, 0);
    add_entry(OP_WRITE, 3, 4'b0101, 2'b00, 2'b00, 1'b1, 3);
    add_entry(OP_WRITE, 3, 4'b1011, 2'b00, 2'b00, 1'b1, 3);
    add_entry(OP_WRITE, 3, 4'b1101, 2'b00, 2'b00, 1'b1, 3);
    // Press, release, then a one-sample low pulse
    add_entry(OP_BTN, 4, 4'h0, 2'b11, 2'b01, 1'b0, STRETCH + 4);
    add_entry(OP_BTN, 4, 4'h0, 2'b11, 2'b01, 1'b1, STRETCH + 4);
    add_entry(OP_BTN, 4, 4'h0, 2'b11, 2'b01, 1'b0, 1);
    add_entry(OP_BTN, 4, 4'h0, 2'b11, 2'b01, 1'b1, STRETCH + 4);
    limit = table_q.size() * 6 + 50;

    repeat (2) @(posedge bus_clk);
    #1;
    bus_rst = 1'b0;
    check_outputs();
    check_val("o_cfg_ready", 32'(o_cfg_ready), 32'd1);
    check_val("o_press_irq", 32'(o_press_irq), 32'd0);
    check_val("o_release_irq", 32'(o_release_irq), 32'd0);
    report(0);

    cur_test = 1;
    foreach (table_q[i]) begin
      e = table_q[i];
      if (e.test_id != cur_test) begin
        report(cur_test);
        cur_test = e.test_id;
      end
      case (e.op)
        OP_WRITE: do_write(e.addr, e.data, e.wait_cyc == 0);
        OP_ATR: begin
          i_rx_atr = e.rx;
          i_tx_atr = e.tx;
        end
        default: i_onswitch_n = e.level;
      endcase
      repeat (e.wait_cyc) step();
      if (e.wait_cyc > 0) check_outputs();
    end
    // Two press events and one release, each a full pulse
    check_val("o_press_irq high cycles", 32'(press_hi), 32'(2 * STRETCH));
    check_val("o_release_irq high cycles", 32'(release_hi), 32'(STRETCH));
    report(cur_test);

    $display("%0d tests, %0d checks, %0d errors", cur_test + 1, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/fe_cfg_pkg.sv
hdl/fe_pins_pkg.sv
hdl/fe_chan_if.sv
hdl/fe_reg_decode.sv
hdl/fe_atr_chan.sv
hdl/fe_pin_map.sv
hdl/pwr_button_irq.sv
hdl/e31x_fe_ctrl.sv
verification/tb_e31x_fe_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_e31x_fe_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_e31x_fe_ctrl)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi
